/* rtl/llc_defines.svh */
// cache geometry and queue depth macros

`ifndef LLC_DEFINES_SVH
`define LLC_DEFINES_SVH

// associativity
`define LLC_WAYS 4

// set index width, 16 sets
`define LLC_SET_BITS 4

// line address width
`define LLC_ADDR_BITS 16

// one line of data
`define LLC_LINE_BITS 64

// entries between decoder and process
`define LLC_FIFO_DEPTH 2

`endif

/* rtl/llc_cfg_pkg.sv */
// cache geometry types: set, tag, way, address, line and line state

`include "llc_defines.svh"

package llc_cfg_pkg;

    localparam int WAY_BITS = $clog2(`LLC_WAYS);
    localparam int TAG_BITS = `LLC_ADDR_BITS - `LLC_SET_BITS;

    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [TAG_BITS-1:0] llc_tag_t;
    typedef logic [WAY_BITS-1:0] llc_way_t;

    // address is {tag, set}
    typedef logic [`LLC_ADDR_BITS-1:0] line_addr_t;
    typedef logic [`LLC_LINE_BITS-1:0] line_t;

    // per-way state bits
    typedef struct packed {
        logic valid;
        logic dirty;
    } llc_state_t;

endpackage

/* rtl/llc_msg_pkg.sv */
// channel messages and pipeline packets

package llc_msg_pkg;

    // request channel, full-line read or write
    typedef struct packed {
        logic write;
        llc_cfg_pkg::line_addr_t addr;
        llc_cfg_pkg::line_t line;
    } llc_req_t;

    typedef struct packed {
        llc_cfg_pkg::line_addr_t addr;
        llc_cfg_pkg::line_t line;
    } llc_rsp_t;

    // write set for writebacks, clear for fills
    typedef struct packed {
        logic write;
        llc_cfg_pkg::line_addr_t addr;
        llc_cfg_pkg::line_t line;
    } llc_mem_req_t;

    typedef struct packed {
        llc_cfg_pkg::line_t line;
    } llc_mem_rsp_t;

    // decoder fifo entry
    typedef struct packed {
        logic write;
        llc_cfg_pkg::llc_set_t set;
        llc_cfg_pkg::llc_tag_t tag;
        llc_cfg_pkg::line_t line;
    } llc_dec_pkt_t;

    // process to update hand-off
    typedef struct packed {
        llc_cfg_pkg::llc_set_t set;
        llc_cfg_pkg::llc_way_t way;
        llc_cfg_pkg::llc_tag_t tag;
        llc_cfg_pkg::line_t line;
        llc_cfg_pkg::llc_state_t state;
        logic evict_adv;
        llc_cfg_pkg::llc_way_t evict_way;
        llc_cfg_pkg::line_t rsp_line;
        llc_cfg_pkg::line_addr_t rsp_addr;
    } llc_upd_pkt_t;

endpackage

/* rtl/llc_fifo.sv */
// circular buffer fifo with a type-parameterized payload

`timescale 1ns/1ps

module llc_fifo #(
    parameter type dtype = llc_cfg_pkg::line_t,
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic push_i,
    input  dtype data_i,
    input  logic pop_i,
    output dtype data_o,
    output logic full_o,
    output logic empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dtype mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic do_push;
    logic do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full_o = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop = pop_i && !empty_o;

    // head entry is visible without a pop
    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst) !(push_i && full_o));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst) !(pop_i && empty_o));

endmodule

/* rtl/llc_input_decoder.sv */
// request intake, splits the line address into set and tag

`timescale 1ns/1ps

module llc_input_decoder (
    input  logic                      req_valid_i,
    input  llc_msg_pkg::llc_req_t     req_i,
    input  logic                      fifo_full_i,
    output logic                      req_ready_o,
    output logic                      push_o,
    output llc_msg_pkg::llc_dec_pkt_t pkt_o
);

    llc_cfg_pkg::llc_set_t req_set;
    llc_cfg_pkg::llc_tag_t req_tag;

    // low bits index the set
    assign {req_tag, req_set} = req_i.addr;

    // accept whenever the queue has room
    assign req_ready_o = !fifo_full_i;
    assign push_o = req_valid_i && !fifo_full_i;

    always_comb begin
        pkt_o.write = req_i.write;
        pkt_o.set = req_set;
        pkt_o.tag = req_tag;
        pkt_o.line = req_i.line;
    end

endmodule

/* rtl/llc_localmem.sv */
// tag, state, line and evict pointer arrays with registered read port

`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_localmem (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_en_i,
    input  llc_cfg_pkg::llc_set_t      rd_set_i,
    output llc_cfg_pkg::llc_tag_t      rd_tags_o [`LLC_WAYS],
    output llc_cfg_pkg::llc_state_t    rd_states_o [`LLC_WAYS],
    output llc_cfg_pkg::line_t         rd_lines_o [`LLC_WAYS],
    output llc_cfg_pkg::llc_way_t      rd_evict_way_o,
    input  logic                       wr_en_i,
    input  llc_cfg_pkg::llc_set_t      wr_set_i,
    input  llc_cfg_pkg::llc_way_t      wr_way_i,
    input  llc_cfg_pkg::llc_tag_t      wr_tag_i,
    input  llc_cfg_pkg::llc_state_t    wr_state_i,
    input  llc_cfg_pkg::line_t         wr_line_i,
    input  llc_cfg_pkg::llc_way_t      wr_evict_way_i
);

    localparam int SETS = 2 ** `LLC_SET_BITS;

    llc_cfg_pkg::llc_tag_t   tags_q [SETS][`LLC_WAYS];
    llc_cfg_pkg::llc_state_t states_q [SETS][`LLC_WAYS];
    llc_cfg_pkg::line_t      lines_q [SETS][`LLC_WAYS];
    llc_cfg_pkg::llc_way_t   evict_q [SETS];

    // state and evict pointers start cleared
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                evict_q[s] <= '0;
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    states_q[s][w] <= '0;
                end
            end
        end else if (wr_en_i) begin
            states_q[wr_set_i][wr_way_i] <= wr_state_i;
            evict_q[wr_set_i] <= wr_evict_way_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags_q[wr_set_i][wr_way_i] <= wr_tag_i;
            lines_q[wr_set_i][wr_way_i] <= wr_line_i;
        end
    end

    // all ways of the set, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_tags_o <= tags_q[rd_set_i];
            rd_states_o <= states_q[rd_set_i];
            rd_lines_o <= lines_q[rd_set_i];
            rd_evict_way_o <= evict_q[rd_set_i];
        end
    end

endmodule

/* rtl/llc_process.sv */
// hit/miss decision, victim choice and the memory fill/writeback sequencer

`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_process (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fifo_empty_i,
    input  llc_msg_pkg::llc_dec_pkt_t     pkt_i,
    output logic                          pop_o,
    output logic                          rd_en_o,
    output llc_cfg_pkg::llc_set_t         rd_set_o,
    input  llc_cfg_pkg::llc_tag_t         rd_tags_i [`LLC_WAYS],
    input  llc_cfg_pkg::llc_state_t       rd_states_i [`LLC_WAYS],
    input  llc_cfg_pkg::line_t            rd_lines_i [`LLC_WAYS],
    input  llc_cfg_pkg::llc_way_t         rd_evict_way_i,
    output logic                          mem_req_valid_o,
    output llc_msg_pkg::llc_mem_req_t     mem_req_o,
    input  logic                          mem_req_ready_i,
    input  logic                          mem_rsp_valid_i,
    input  llc_msg_pkg::llc_mem_rsp_t     mem_rsp_i,
    output logic                          mem_rsp_ready_o,
    output logic                          upd_valid_o,
    output llc_msg_pkg::llc_upd_pkt_t     upd_o,
    input  logic                          upd_done_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_FILL,
        S_HAND,
        S_WAIT
    } state_t;

    state_t state_q, state_d;
    logic fill_sent_q;
    logic mem_req_fire;
    logic mem_rsp_fire;

    llc_msg_pkg::llc_dec_pkt_t pkt_q;
    llc_cfg_pkg::llc_way_t way_q;
    llc_cfg_pkg::llc_tag_t vic_tag_q;
    llc_cfg_pkg::llc_state_t old_state_q;
    llc_cfg_pkg::line_t line_q;
    llc_cfg_pkg::llc_way_t evict_q;
    logic hit_q;
    logic adv_q;

    // lookup results
    logic hit;
    logic has_inv;
    llc_cfg_pkg::llc_way_t hit_way;
    llc_cfg_pkg::llc_way_t inv_way;
    llc_cfg_pkg::llc_way_t way_sel;
    logic need_wb;

    assign pop_o = (state_q == S_IDLE) && !fifo_empty_i;
    assign rd_en_o = pop_o;
    assign rd_set_o = pkt_i.set;

    // descending scan leaves the lowest matching way
    always_comb begin
        hit = 1'b0;
        has_inv = 1'b0;
        hit_way = '0;
        inv_way = '0;
        for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
            if (rd_states_i[w].valid && rd_tags_i[w] == pkt_q.tag) begin
                hit = 1'b1;
                hit_way = llc_cfg_pkg::llc_way_t'(w);
            end
            if (!rd_states_i[w].valid) begin
                has_inv = 1'b1;
                inv_way = llc_cfg_pkg::llc_way_t'(w);
            end
        end
        way_sel = hit ? hit_way : (has_inv ? inv_way : rd_evict_way_i);
        need_wb = !hit && rd_states_i[way_sel].valid && rd_states_i[way_sel].dirty;
    end

    assign mem_req_valid_o = (state_q == S_WB) || (state_q == S_FILL && !fill_sent_q);
    assign mem_rsp_ready_o = (state_q == S_FILL) && fill_sent_q;
    assign mem_req_fire = mem_req_valid_o && mem_req_ready_i;
    assign mem_rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;
    assign upd_valid_o = (state_q == S_HAND);

    // writeback of the victim, or a fill for the requested line
    always_comb begin
        if (state_q == S_WB) begin
            mem_req_o.write = 1'b1;
            mem_req_o.addr = {vic_tag_q, pkt_q.set};
            mem_req_o.line = line_q;
        end else begin
            mem_req_o.write = 1'b0;
            mem_req_o.addr = {pkt_q.tag, pkt_q.set};
            mem_req_o.line = '0;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: if (pop_o) state_d = S_LOOKUP;
            S_LOOKUP: begin
                if (need_wb) begin
                    state_d = S_WB;
                end else if (hit || pkt_q.write) begin
                    state_d = S_HAND;
                end else begin
                    state_d = S_FILL;
                end
            end
            S_WB: if (mem_req_fire) state_d = pkt_q.write ? S_HAND : S_FILL;
            S_FILL: if (mem_rsp_fire) state_d = S_HAND;
            S_HAND: state_d = S_WAIT;
            S_WAIT: if (upd_done_i) state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= S_IDLE;
            fill_sent_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_FILL && mem_req_fire) begin
                fill_sent_q <= 1'b1;
            end else if (mem_rsp_fire) begin
                fill_sent_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            pkt_q <= pkt_i;
        end
        if (state_q == S_LOOKUP) begin
            hit_q <= hit;
            way_q <= way_sel;
            vic_tag_q <= rd_tags_i[way_sel];
            old_state_q <= rd_states_i[way_sel];
            line_q <= rd_lines_i[way_sel];
            evict_q <= rd_evict_way_i;
            adv_q <= !hit && !has_inv;
        end
        if (mem_rsp_fire) begin
            line_q <= mem_rsp_i.line;
        end
    end

    // writes go in dirty, hits keep their dirty bit, fills go in clean
    always_comb begin
        upd_o.set = pkt_q.set;
        upd_o.way = way_q;
        upd_o.tag = pkt_q.tag;
        upd_o.line = pkt_q.write ? pkt_q.line : line_q;
        upd_o.state.valid = 1'b1;
        upd_o.state.dirty = pkt_q.write || (hit_q && old_state_q.dirty);
        upd_o.evict_adv = adv_q;
        upd_o.evict_way = evict_q;
        upd_o.rsp_line = upd_o.line;
        upd_o.rsp_addr = {pkt_q.tag, pkt_q.set};
    end

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

/* rtl/llc_update.sv */
// array write, evict pointer advance and response hold

`timescale 1ns/1ps

module llc_update (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       upd_valid_i,
    input  llc_msg_pkg::llc_upd_pkt_t  upd_i,
    output logic                       wr_en_o,
    output llc_cfg_pkg::llc_set_t      wr_set_o,
    output llc_cfg_pkg::llc_way_t      wr_way_o,
    output llc_cfg_pkg::llc_tag_t      wr_tag_o,
    output llc_cfg_pkg::llc_state_t    wr_state_o,
    output llc_cfg_pkg::line_t         wr_line_o,
    output llc_cfg_pkg::llc_way_t      wr_evict_way_o,
    output logic                       rsp_valid_o,
    output llc_msg_pkg::llc_rsp_t      rsp_o,
    input  logic                       rsp_ready_i,
    output logic                       upd_done_o
);

    llc_msg_pkg::llc_upd_pkt_t upd_q;
    logic wr_en_q;
    logic rsp_pending_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_en_q <= 1'b0;
            rsp_pending_q <= 1'b0;
        end else begin
            wr_en_q <= upd_valid_i;
            if (upd_valid_i) begin
                rsp_pending_q <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            upd_q <= upd_i;
        end
    end

    // single write cycle right after the hand-off
    assign wr_en_o = wr_en_q;
    assign wr_set_o = upd_q.set;
    assign wr_way_o = upd_q.way;
    assign wr_tag_o = upd_q.tag;
    assign wr_state_o = upd_q.state;
    assign wr_line_o = upd_q.line;

    // victim was the pointer, so the pointer moves past it
    assign wr_evict_way_o = upd_q.evict_adv ? upd_q.way + 1'b1 : upd_q.evict_way;

    assign rsp_valid_o = rsp_pending_q;
    assign rsp_o.addr = upd_q.rsp_addr;
    assign rsp_o.line = upd_q.rsp_line;
    assign upd_done_o = rsp_valid_o && rsp_ready_i;

    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

/* rtl/llc_core.sv */
// cache core top: decoder, request fifo, local memory, process and update

`timescale 1ns/1ps
`include "llc_defines.svh"

module llc_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  llc_msg_pkg::llc_req_t      req_i,
    output logic                       req_ready_o,
    output logic                       rsp_valid_o,
    output llc_msg_pkg::llc_rsp_t      rsp_o,
    input  logic                       rsp_ready_i,
    output logic                       mem_req_valid_o,
    output llc_msg_pkg::llc_mem_req_t  mem_req_o,
    input  logic                       mem_req_ready_i,
    input  logic                       mem_rsp_valid_i,
    input  llc_msg_pkg::llc_mem_rsp_t  mem_rsp_i,
    output logic                       mem_rsp_ready_o
);

    // decoder to fifo to process
    logic fifo_push;
    logic fifo_pop;
    logic fifo_full;
    logic fifo_empty;
    llc_msg_pkg::llc_dec_pkt_t dec_pkt;
    llc_msg_pkg::llc_dec_pkt_t fifo_pkt;

    // local memory ports
    logic rd_en;
    llc_cfg_pkg::llc_set_t rd_set;
    llc_cfg_pkg::llc_tag_t rd_tags [`LLC_WAYS];
    llc_cfg_pkg::llc_state_t rd_states [`LLC_WAYS];
    llc_cfg_pkg::line_t rd_lines [`LLC_WAYS];
    llc_cfg_pkg::llc_way_t rd_evict_way;
    logic wr_en;
    llc_cfg_pkg::llc_set_t wr_set;
    llc_cfg_pkg::llc_way_t wr_way;
    llc_cfg_pkg::llc_tag_t wr_tag;
    llc_cfg_pkg::llc_state_t wr_state;
    llc_cfg_pkg::line_t wr_line;
    llc_cfg_pkg::llc_way_t wr_evict_way;

    // process to update
    logic upd_valid;
    logic upd_done;
    llc_msg_pkg::llc_upd_pkt_t upd_pkt;

    llc_input_decoder u_decoder (
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .fifo_full_i (fifo_full),
        .req_ready_o (req_ready_o),
        .push_o      (fifo_push),
        .pkt_o       (dec_pkt)
    );

    llc_fifo #(
        .dtype (llc_msg_pkg::llc_dec_pkt_t),
        .DEPTH (`LLC_FIFO_DEPTH)
    ) u_req_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (fifo_push),
        .data_i  (dec_pkt),
        .pop_i   (fifo_pop),
        .data_o  (fifo_pkt),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    llc_localmem u_localmem (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en),
        .rd_set_i       (rd_set),
        .rd_tags_o      (rd_tags),
        .rd_states_o    (rd_states),
        .rd_lines_o     (rd_lines),
        .rd_evict_way_o (rd_evict_way),
        .wr_en_i        (wr_en),
        .wr_set_i       (wr_set),
        .wr_way_i       (wr_way),
        .wr_tag_i       (wr_tag),
        .wr_state_i     (wr_state),
        .wr_line_i      (wr_line),
        .wr_evict_way_i (wr_evict_way)
    );

    llc_process u_process (
        .clk             (clk),
        .rst             (rst),
        .fifo_empty_i    (fifo_empty),
        .pkt_i           (fifo_pkt),
        .pop_o           (fifo_pop),
        .rd_en_o         (rd_en),
        .rd_set_o        (rd_set),
        .rd_tags_i       (rd_tags),
        .rd_states_i     (rd_states),
        .rd_lines_i      (rd_lines),
        .rd_evict_way_i  (rd_evict_way),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .upd_valid_o     (upd_valid),
        .upd_o           (upd_pkt),
        .upd_done_i      (upd_done)
    );

    llc_update u_update (
        .clk            (clk),
        .rst            (rst),
        .upd_valid_i    (upd_valid),
        .upd_i          (upd_pkt),
        .wr_en_o        (wr_en),
        .wr_set_o       (wr_set),
        .wr_way_o       (wr_way),
        .wr_tag_o       (wr_tag),
        .wr_state_o     (wr_state),
        .wr_line_o      (wr_line),
        .wr_evict_way_o (wr_evict_way),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_o          (rsp_o),
        .rsp_ready_i    (rsp_ready_i),
        .upd_done_o     (upd_done)
    );

endmodule

/* tb/tb_llc_core.sv */
// testbench for the cache core: memory model, reference cache model,
// directed tests and timeout

`timescale 1ns/1ps
`include "llc_defines.svh"

module tb_llc_core;

    localparam int SETS = 2 ** `LLC_SET_BITS;
    // about 14 accesses, each well under 100 cycles including stalls
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic rst;
    logic req_valid_i;
    llc_msg_pkg::llc_req_t req_i;
    logic req_ready_o;
    logic rsp_valid_o;
    llc_msg_pkg::llc_rsp_t rsp_o;
    logic rsp_ready_i;
    logic mem_req_valid_o;
    llc_msg_pkg::llc_mem_req_t mem_req_o;
    logic mem_req_ready_i;
    logic mem_rsp_valid_i;
    llc_msg_pkg::llc_mem_rsp_t mem_rsp_i;
    logic mem_rsp_ready_o;

    int cycles = 0;

    // observed transfers and outstanding fills
    llc_msg_pkg::llc_rsp_t rsp_q [$];
    llc_msg_pkg::llc_mem_req_t mem_log [$];
    llc_cfg_pkg::line_addr_t fill_q [$];

    // reference cache state and expected traffic
    llc_cfg_pkg::llc_tag_t ref_tag [SETS][`LLC_WAYS];
    llc_cfg_pkg::line_t ref_line [SETS][`LLC_WAYS];
    logic ref_valid [SETS][`LLC_WAYS];
    logic ref_dirty [SETS][`LLC_WAYS];
    int ref_evict [SETS];
    llc_msg_pkg::llc_rsp_t exp_rsp_q [$];
    llc_msg_pkg::llc_mem_req_t exp_mem_q [$];

    llc_core u_dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a response or memory request never came", cycles);
            $display("Finished with errors");
            $fatal(1, "simulation timed out");
        end
    end

    // transfer monitor, values seen here are the ones present at the edge
    always @(posedge clk) begin
        if (rsp_valid_o && rsp_ready_i) begin
            rsp_q.push_back(rsp_o);
        end
        if (mem_rsp_valid_i && mem_rsp_ready_o && fill_q.size() > 0) begin
            fill_q.delete(0);
        end
        if (mem_req_valid_o && mem_req_ready_i) begin
            mem_log.push_back(mem_req_o);
            if (!mem_req_o.write) begin
                fill_q.push_back(mem_req_o.addr);
            end
        end
    end

    // memory model, a fill returns the line address repeated four times
    initial begin
        mem_rsp_valid_i = 1'b0;
        mem_rsp_i = '0;
        forever begin
            @(negedge clk);
            if (fill_q.size() > 0) begin
                mem_rsp_valid_i = 1'b1;
                mem_rsp_i.line = {4{fill_q[0]}};
            end else begin
                mem_rsp_valid_i = 1'b0;
            end
        end
    end

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "check failed");
        end
    endtask

    // hit, invalid-first victim, round-robin pointer, writeback before fill
    task automatic expect_access(input logic wr, input llc_cfg_pkg::line_addr_t addr,
                                 input llc_cfg_pkg::line_t data);
        int set;
        int way;
        logic hit;
        logic found_inv;
        llc_cfg_pkg::llc_tag_t tag;
        llc_msg_pkg::llc_mem_req_t mreq;
        llc_msg_pkg::llc_rsp_t rsp;
        set = int'(addr[`LLC_SET_BITS-1:0]);
        tag = addr[`LLC_ADDR_BITS-1:`LLC_SET_BITS];
        hit = 1'b0;
        found_inv = 1'b0;
        way = 0;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (!hit && ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                if (!found_inv && !ref_valid[set][w]) begin
                    found_inv = 1'b1;
                    way = w;
                end
            end
            if (!found_inv) begin
                way = ref_evict[set];
                ref_evict[set] = (ref_evict[set] + 1) % `LLC_WAYS;
            end
            if (ref_valid[set][way] && ref_dirty[set][way]) begin
                mreq.write = 1'b1;
                mreq.addr = {ref_tag[set][way], addr[`LLC_SET_BITS-1:0]};
                mreq.line = ref_line[set][way];
                exp_mem_q.push_back(mreq);
            end
            if (!wr) begin
                mreq.write = 1'b0;
                mreq.addr = addr;
                mreq.line = '0;
                exp_mem_q.push_back(mreq);
            end
        end
        rsp.addr = addr;
        rsp.line = wr ? data : (hit ? ref_line[set][way] : {4{addr}});
        exp_rsp_q.push_back(rsp);
        ref_dirty[set][way] = wr || (hit && ref_dirty[set][way]);
        ref_valid[set][way] = 1'b1;
        ref_tag[set][way] = tag;
        ref_line[set][way] = rsp.line;
    endtask

    task automatic send_req(input logic wr, input llc_cfg_pkg::line_addr_t addr,
                            input llc_cfg_pkg::line_t data);
        @(negedge clk);
        req_valid_i = 1'b1;
        req_i.write = wr;
        req_i.addr = addr;
        req_i.line = data;
        // ready only moves at a rising edge
        while (!req_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic issue_access(input logic wr, input llc_cfg_pkg::line_addr_t addr,
                                input llc_cfg_pkg::line_t data);
        expect_access(wr, addr, data);
        send_req(wr, addr, data);
    endtask

    // waits for all outstanding responses, then compares in order
    task automatic drain_and_check();
        llc_msg_pkg::llc_rsp_t got;
        llc_msg_pkg::llc_rsp_t exp;
        llc_msg_pkg::llc_mem_req_t got_m;
        llc_msg_pkg::llc_mem_req_t exp_m;
        while (rsp_q.size() < exp_rsp_q.size()) begin
            @(negedge clk);
        end
        check_hex("rsp count", 64'(rsp_q.size()), 64'(exp_rsp_q.size()));
        check_hex("mem_req count", 64'(mem_log.size()), 64'(exp_mem_q.size()));
        while (exp_rsp_q.size() > 0) begin
            got = rsp_q.pop_front();
            exp = exp_rsp_q.pop_front();
            check_hex("rsp_o.addr", 64'(got.addr), 64'(exp.addr));
            check_hex("rsp_o.line", got.line, exp.line);
        end
        while (exp_mem_q.size() > 0) begin
            got_m = mem_log.pop_front();
            exp_m = exp_mem_q.pop_front();
            check_hex("mem_req_o.write", 64'(got_m.write), 64'(exp_m.write));
            check_hex("mem_req_o.addr", 64'(got_m.addr), 64'(exp_m.addr));
            if (exp_m.write) begin
                check_hex("mem_req_o.line", got_m.line, exp_m.line);
            end
        end
    endtask

    task automatic check_reset_outputs();
        check_hex("rsp_valid_o", 64'(rsp_valid_o), 64'h0);
        check_hex("mem_req_valid_o", 64'(mem_req_valid_o), 64'h0);
        check_hex("mem_rsp_ready_o", 64'(mem_rsp_ready_o), 64'h0);
        check_hex("req_ready_o", 64'(req_ready_o), 64'h1);
    endtask

    task automatic test_read_miss();
        issue_access(1'b0, 16'h0123, '0);
        drain_and_check();
    endtask

    task automatic test_read_hit();
        issue_access(1'b0, 16'h0123, '0);
        drain_and_check();
    endtask

    task automatic test_write_read();
        issue_access(1'b1, 16'h0457, {$urandom, $urandom});
        issue_access(1'b0, 16'h0457, '0);
        drain_and_check();
    endtask

    // five tags into set 5 force a dirty victim, the sixth read evicts again
    task automatic test_eviction();
        for (int i = 1; i <= 5; i++) begin
            issue_access(1'b1, {12'(i), 4'h5}, {$urandom, $urandom});
        end
        issue_access(1'b0, {12'h006, 4'h5}, '0);
        drain_and_check();
    endtask

    task automatic test_rsp_backpressure();
        llc_msg_pkg::llc_rsp_t exp;
        rsp_ready_i = 1'b0;
        issue_access(1'b0, 16'h0123, '0);
        issue_access(1'b0, 16'h0457, '0);
        issue_access(1'b1, 16'h0a03, {$urandom, $urandom});
        // first request stuck in update, the other two fill the fifo
        check_hex("req_ready_o", 64'(req_ready_o), 64'h0);
        while (!rsp_valid_o) begin
            @(negedge clk);
        end
        // the held response is the oldest one the model expects
        exp = exp_rsp_q[0];
        repeat (5) begin
            @(negedge clk);
            check_hex("rsp_valid_o", 64'(rsp_valid_o), 64'h1);
            check_hex("rsp_o.addr", 64'(rsp_o.addr), 64'(exp.addr));
            check_hex("rsp_o.line", rsp_o.line, exp.line);
        end
        check_hex("rsp count", 64'(rsp_q.size()), 64'h0);
        rsp_ready_i = 1'b1;
        drain_and_check();
    endtask

    task automatic test_mem_backpressure();
        llc_msg_pkg::llc_mem_req_t exp;
        mem_req_ready_i = 1'b0;
        issue_access(1'b0, 16'h0999, '0);
        while (!mem_req_valid_o) begin
            @(negedge clk);
        end
        exp = exp_mem_q[0];
        repeat (4) begin
            @(negedge clk);
            check_hex("mem_req_valid_o", 64'(mem_req_valid_o), 64'h1);
            check_hex("mem_req_o.write", 64'(mem_req_o.write), 64'(exp.write));
            check_hex("mem_req_o.addr", 64'(mem_req_o.addr), 64'(exp.addr));
            if (exp.write) begin
                check_hex("mem_req_o.line", mem_req_o.line, exp.line);
            end
        end
        mem_req_ready_i = 1'b1;
        drain_and_check();
    endtask

    initial begin
        rst = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        rsp_ready_i = 1'b1;
        mem_req_ready_i = 1'b1;
        void'($urandom(32'hb2b5));
        for (int s = 0; s < SETS; s++) begin
            ref_evict[s] = 0;
            for (int w = 0; w < `LLC_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (3) @(negedge clk);
        check_reset_outputs();
        rst = 1'b1;
        test_read_miss();
        test_read_hit();
        test_write_read();
        test_eviction();
        test_rsp_backpressure();
        test_mem_backpressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/llc_cfg_pkg.sv
rtl/llc_msg_pkg.sv
rtl/llc_fifo.sv
rtl/llc_input_decoder.sv
rtl/llc_localmem.sv
rtl/llc_process.sv
rtl/llc_update.sv
rtl/llc_core.sv
tb/tb_llc_core.sv

/* Makefile */
TOP = tb_llc_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module llc_core
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
